/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f multicore_lock.f --top-module mc_top

sim:
	verilator --binary --timing --assert -f multicore_lock.f --top-module mc_tb -Mdir obj_dir
	./obj_dir/Vmc_tb | tee /dev/stderr | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* design/core.sv */
`default_nettype none

module core (
   input  logic            clk,
   input  logic            reset_n,
   input  logic            run,
   input  mc_pkg::word_t   inst,
   input  logic            mem_ack,
   input  mc_pkg::word_t   mem_rdat,
   output mc_pkg::iadr_t   pc,
   output logic            mem_req,
   output mc_pkg::mem_op_t mem_op,
   output mc_pkg::dadr_t   mem_adr,
   output mc_pkg::word_t   mem_wdat,
   output logic            halt
);

   mc_pkg::core_state_t state;
   mc_pkg::word_t       regs [4];
   mc_pkg::opcode_t     opcode;
   mc_pkg::reg_idx_t    rd;
   mc_pkg::reg_idx_t    rs;
   mc_pkg::reg_idx_t    ld_rd;   // Destination of a pending load.
   mc_pkg::dadr_t       imm;
   mc_pkg::mem_op_t     req_op;
   logic                is_mem;

   assign opcode = inst[15:12];
   assign rd     = inst[11:10];
   assign rs     = inst[9:8];
   assign imm    = inst[7:0];

   always_comb begin
      is_mem = 1'b1;
      req_op = mc_pkg::mem_read;
      case (opcode)
         mc_pkg::op_ld:     req_op = mc_pkg::mem_read;
         mc_pkg::op_st:     req_op = mc_pkg::mem_write;
         mc_pkg::op_lock:   req_op = mc_pkg::mem_lock;
         mc_pkg::op_unlock: req_op = mc_pkg::mem_unlock;
         default:           is_mem = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state   <= mc_pkg::idle;
         pc      <= '0;
         mem_req <= 1'b0;
         halt    <= 1'b0;
      end else begin
         case (state)
            mc_pkg::idle: begin
               if (run) begin
                  state <= mc_pkg::fetch;
               end
            end
            mc_pkg::fetch: begin
               state <= mc_pkg::exec;          // inst is valid next cycle.
            end
            mc_pkg::exec: begin
               if (opcode == mc_pkg::op_halt) begin
                  state <= mc_pkg::halted;
                  halt  <= 1'b1;
               end else if (is_mem) begin
                  mem_req <= 1'b1;
                  state   <= mc_pkg::mem_wait;
               end else begin
                  pc    <= pc + mc_pkg::iadr_t'(1);
                  state <= mc_pkg::fetch;
               end
            end
            mc_pkg::mem_wait: begin
               if (mem_ack) begin
                  mem_req <= 1'b0;
                  state   <= mc_pkg::mem_release;
               end
            end
            mc_pkg::mem_release: begin
               if (!mem_ack) begin
                  pc    <= pc + mc_pkg::iadr_t'(1);
                  state <= mc_pkg::fetch;
               end
            end
            default: begin
               state <= mc_pkg::halted;        // Stays here until reset.
            end
         endcase
      end
   end

   // Register file and request payload.
   always_ff @(posedge clk) begin
      if (state == mc_pkg::exec) begin
         case (opcode)
            mc_pkg::op_ldi: regs[rd] <= mc_pkg::word_t'(imm);
            mc_pkg::op_add: regs[rd] <= regs[rd] + regs[rs];
            default: begin
            end
         endcase
         mem_op   <= req_op;
         mem_adr  <= imm;
         mem_wdat <= regs[rd];
         ld_rd    <= rd;
      end
      if (state == mc_pkg::mem_wait && mem_ack && mem_op == mc_pkg::mem_read) begin
         regs[ld_rd] <= mem_rdat;                // Load data valid with ack.
      end
   end

endmodule

`default_nettype wire

/* design/inst_mem.sv */
`default_nettype none

module inst_mem (
   input  logic             clk,
   input  mc_pkg::core_id_t core_idx,
   input  logic             prog_we,
   input  mc_pkg::core_id_t prog_core,
   input  mc_pkg::iadr_t    prog_adr,
   input  mc_pkg::word_t    prog_dat,
   input  mc_pkg::iadr_t    pc,
   output mc_pkg::word_t    inst
);

   mc_pkg::word_t mem [mc_pkg::imem_words];
   logic          sel;

   assign sel = prog_we && (prog_core == core_idx); // Only this core's image.

   always_ff @(posedge clk) begin
      if (sel) begin
         mem[prog_adr] <= prog_dat;
      end
   end

   // The word at pc shows up one cycle later.
   always_ff @(posedge clk) begin
      inst <= mem[pc];
   end

endmodule

`default_nettype wire

/* design/main_mem.sv */
`default_nettype none

module main_mem (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic [mc_pkg::num_cores-1:0] mem_req,
   input  mc_pkg::mem_op_t              mem_op [mc_pkg::num_cores],
   input  mc_pkg::dadr_t                mem_adr [mc_pkg::num_cores],
   input  mc_pkg::word_t                mem_wdat [mc_pkg::num_cores],
   output logic [mc_pkg::num_cores-1:0] mem_ack,
   output mc_pkg::word_t                mem_rdat [mc_pkg::num_cores],
   input  mc_pkg::dadr_t                peek_adr,
   output mc_pkg::word_t                peek_dat
);

   mc_pkg::word_t    dmem [mc_pkg::dmem_words];
   logic [mc_pkg::lock_slots-1:0] slot_valid;
   mc_pkg::dadr_t    slot_adr [mc_pkg::lock_slots];
   mc_pkg::core_id_t slot_owner [mc_pkg::lock_slots];
   logic [mc_pkg::num_cores-1:0]  own_hit;
   logic [mc_pkg::num_cores-1:0]  other_hit;
   logic [mc_pkg::num_cores-1:0]  eligible;
   mc_pkg::slot_idx_t own_idx [mc_pkg::num_cores];
   mc_pkg::slot_idx_t free_idx;
   logic             free_found;
   logic             busy;
   logic             do_op;
   mc_pkg::core_id_t cur;
   mc_pkg::core_id_t prio;       // Core that wins the next tie.
   logic             pick_valid;
   mc_pkg::core_id_t pick;

   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int s = mc_pkg::lock_slots - 1; s >= 0; s--) begin
         if (!slot_valid[s]) begin
            free_found = 1'b1;
            free_idx   = mc_pkg::slot_idx_t'(s);    // Lowest free slot wins.
         end
      end
      for (int c = 0; c < mc_pkg::num_cores; c++) begin
         own_hit[c]   = 1'b0;
         other_hit[c] = 1'b0;
         own_idx[c]   = '0;
         for (int s = 0; s < mc_pkg::lock_slots; s++) begin
            if (slot_valid[s] && slot_adr[s] == mem_adr[c]) begin
               if (slot_owner[s] == mc_pkg::core_id_t'(c)) begin
                  own_hit[c] = 1'b1;
                  own_idx[c] = mc_pkg::slot_idx_t'(s);
               end else begin
                  other_hit[c] = 1'b1;
               end
            end
         end
         // A blocked lock is simply not served yet.
         eligible[c] = mem_req[c] && !mem_ack[c] &&
                       (mem_op[c] != mc_pkg::mem_lock ||
                        (!other_hit[c] && (own_hit[c] || free_found)));
      end
   end

   assign pick_valid = eligible[prio] || eligible[~prio];
   assign pick       = eligible[prio] ? prio : ~prio;
   assign do_op      = busy && !mem_ack[cur];
   assign peek_dat   = dmem[peek_adr];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy       <= 1'b0;
         cur        <= '0;
         prio       <= '0;
         mem_ack    <= '0;
         slot_valid <= '0;
      end else if (!busy) begin
         if (pick_valid) begin
            busy <= 1'b1;
            cur  <= pick;
         end
      end else if (do_op) begin
         mem_ack[cur] <= 1'b1;
         if (mem_op[cur] == mc_pkg::mem_lock && !own_hit[cur]) begin
            slot_valid[free_idx] <= 1'b1;
         end
         if (mem_op[cur] == mc_pkg::mem_unlock && own_hit[cur]) begin
            slot_valid[own_idx[cur]] <= 1'b0;
         end
      end else if (!mem_req[cur]) begin
         mem_ack[cur] <= 1'b0;
         busy         <= 1'b0;
         prio         <= ~cur;   // Other core goes first next time.
      end
   end

   always_ff @(posedge clk) begin
      if (do_op) begin
         if (mem_op[cur] == mc_pkg::mem_write) begin
            dmem[mem_adr[cur]] <= mem_wdat[cur];
         end
         if (mem_op[cur] == mc_pkg::mem_lock && !own_hit[cur]) begin
            slot_adr[free_idx]   <= mem_adr[cur];
            slot_owner[free_idx] <= cur;
         end
         mem_rdat[cur] <= dmem[mem_adr[cur]];
      end
   end

endmodule

`default_nettype wire

/* design/mc_pkg.sv */
`default_nettype none

package mc_pkg;

   localparam int num_cores  = 2;
   localparam int imem_words = 32;
   localparam int dmem_words = 256;
   localparam int lock_slots = 4;

   typedef logic [15:0] word_t;     // Data and instruction word.
   typedef logic [4:0]  iadr_t;
   typedef logic [7:0]  dadr_t;
   typedef logic [1:0]  reg_idx_t;
   typedef logic [0:0]  core_id_t;
   typedef logic [3:0]  opcode_t;   // Bits 15 to 12 of an instruction.
   typedef logic [1:0]  slot_idx_t; // Lock table slot.
   typedef logic [31:0] count_t;

   // rd sits in bits 11 to 10, rs in 9 to 8, immediate or address in 7 to 0.
   localparam opcode_t op_nop    = 4'h0;
   localparam opcode_t op_ldi    = 4'h1;
   localparam opcode_t op_add    = 4'h2;
   localparam opcode_t op_ld     = 4'h3;
   localparam opcode_t op_st     = 4'h4;
   localparam opcode_t op_lock   = 4'h5;
   localparam opcode_t op_unlock = 4'h6;
   localparam opcode_t op_halt   = 4'hf;

   typedef logic [1:0] mem_op_t;
   localparam mem_op_t mem_read   = 2'd0;
   localparam mem_op_t mem_write  = 2'd1;
   localparam mem_op_t mem_lock   = 2'd2;
   localparam mem_op_t mem_unlock = 2'd3;

   typedef enum logic [2:0] {
      idle,
      fetch,
      exec,
      mem_wait,     // Request up and waiting for ack.
      mem_release,  // Request down and waiting for ack to drop.
      halted
   } core_state_t;

endpackage

`default_nettype wire

/* design/mc_top.sv */
`default_nettype none

module mc_top (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             run,
   input  logic             prog_we,
   input  mc_pkg::core_id_t prog_core,
   input  mc_pkg::iadr_t    prog_adr,
   input  mc_pkg::word_t    prog_dat,
   input  mc_pkg::dadr_t    peek_adr,
   output logic             halted,
   output mc_pkg::count_t   cycles,
   output mc_pkg::word_t    peek_dat
);

   mc_pkg::iadr_t                pc [mc_pkg::num_cores];
   mc_pkg::word_t                inst [mc_pkg::num_cores];
   logic [mc_pkg::num_cores-1:0] mem_req;
   mc_pkg::mem_op_t              mem_op [mc_pkg::num_cores];
   mc_pkg::dadr_t                mem_adr [mc_pkg::num_cores];
   mc_pkg::word_t                mem_wdat [mc_pkg::num_cores];
   logic [mc_pkg::num_cores-1:0] mem_ack;
   mc_pkg::word_t                mem_rdat [mc_pkg::num_cores];
   logic [mc_pkg::num_cores-1:0] halt;

   for (genvar i = 0; i < mc_pkg::num_cores; i++) begin : g_core
      inst_mem i_inst_mem (
         .clk       (clk),
         .core_idx  (mc_pkg::core_id_t'(i)),   // Selects this core's program writes.
         .prog_we   (prog_we),
         .prog_core (prog_core),
         .prog_adr  (prog_adr),
         .prog_dat  (prog_dat),
         .pc        (pc[i]),
         .inst      (inst[i])
      );

      core i_core (
         .clk      (clk),
         .reset_n  (reset_n),
         .run      (run),
         .inst     (inst[i]),
         .mem_ack  (mem_ack[i]),
         .mem_rdat (mem_rdat[i]),
         .pc       (pc[i]),
         .mem_req  (mem_req[i]),
         .mem_op   (mem_op[i]),
         .mem_adr  (mem_adr[i]),
         .mem_wdat (mem_wdat[i]),
         .halt     (halt[i])
      );
   end

   main_mem i_main_mem (
      .clk      (clk),
      .reset_n  (reset_n),
      .mem_req  (mem_req),
      .mem_op   (mem_op),
      .mem_adr  (mem_adr),
      .mem_wdat (mem_wdat),
      .mem_ack  (mem_ack),
      .mem_rdat (mem_rdat),
      .peek_adr (peek_adr),
      .peek_dat (peek_dat)
   );

   run_monitor i_run_monitor (
      .clk     (clk),
      .reset_n (reset_n),
      .run     (run),
      .halt    (halt),
      .halted  (halted),
      .cycles  (cycles)
   );

endmodule

`default_nettype wire

/* design/run_monitor.sv */
`default_nettype none

module run_monitor (
   input  logic                         clk,
   input  logic                         reset_n,
   input  logic                         run,
   input  logic [mc_pkg::num_cores-1:0] halt,
   output logic                         halted,
   output mc_pkg::count_t               cycles
);

   logic all_halt;

   assign all_halt = &halt;   // Every core has finished.

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         halted <= 1'b0;
         cycles <= '0;
      end else begin
         if (all_halt) begin
            halted <= 1'b1;   // Sticky until reset.
         end
         if (run && !halted) begin
            cycles <= cycles + mc_pkg::count_t'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* multicore_lock.f */
+incdir+tb
design/mc_pkg.sv
design/inst_mem.sv
design/core.sv
design/main_mem.sv
design/run_monitor.sv
design/mc_top.sv
tb/mc_tb.sv

/* tb/mc_tb_programs.svh */
`ifndef MC_TB_PROGRAMS_SVH
`define MC_TB_PROGRAMS_SVH

function automatic mc_pkg::word_t enc_nop();
   return {mc_pkg::op_nop, 12'h000};
endfunction
function automatic mc_pkg::word_t enc_ldi(input logic [1:0] rd, input logic [7:0] imm);
   return {mc_pkg::op_ldi, rd, 2'b00, imm};
endfunction
function automatic mc_pkg::word_t enc_add(input logic [1:0] rd, input logic [1:0] rs);
   return {mc_pkg::op_add, rd, rs, 8'h00};
endfunction
function automatic mc_pkg::word_t enc_ld(input logic [1:0] rd, input logic [7:0] adr);
   return {mc_pkg::op_ld, rd, 2'b00, adr};
endfunction
function automatic mc_pkg::word_t enc_st(input logic [1:0] rd, input logic [7:0] adr);
   return {mc_pkg::op_st, rd, 2'b00, adr};
endfunction
function automatic mc_pkg::word_t enc_lock(input logic [7:0] adr);
   return {mc_pkg::op_lock, 4'h0, adr};
endfunction
function automatic mc_pkg::word_t enc_unlock(input logic [7:0] adr);
   return {mc_pkg::op_unlock, 4'h0, adr};
endfunction
function automatic mc_pkg::word_t enc_halt();
   return {mc_pkg::op_halt, 12'h000};
endfunction

task automatic push_nops(input int n);
   repeat (n) prog.push_back(enc_nop());
endtask

// r0 gets x plus y, stored at adr, then halt.
task automatic push_sum(input logic [7:0] x, input logic [7:0] y, input logic [7:0] adr);
   prog.push_back(enc_ldi(2'd0, x));
   prog.push_back(enc_ldi(2'd1, y));
   prog.push_back(enc_add(2'd0, 2'd1));
   prog.push_back(enc_st(2'd0, adr));
   prog.push_back(enc_halt());
endtask

// Four locked increments of the counter at adr.
task automatic push_counter(input logic [7:0] adr, input bit init, input int pad);
   prog.push_back(enc_ldi(2'd1, 8'd1));
   if (init) begin
      prog.push_back(enc_ldi(2'd0, 8'd0));
      prog.push_back(enc_st(2'd0, adr));      // Counter starts at zero.
   end
   push_nops(pad);
   repeat (4) begin
      prog.push_back(enc_lock(adr));
      prog.push_back(enc_ld(2'd0, adr));
      prog.push_back(enc_add(2'd0, 2'd1));
      prog.push_back(enc_st(2'd0, adr));
      prog.push_back(enc_unlock(adr));
   end
   prog.push_back(enc_halt());
endtask

task automatic load_program(input mc_pkg::core_id_t which);
   foreach (prog[i]) begin
      @(posedge clk);
      #1;
      prog_we   = 1'b1;
      prog_core = which;
      prog_adr  = mc_pkg::iadr_t'(i);
      prog_dat  = prog[i];
   end
   @(posedge clk);
   #1;
   prog_we = 1'b0;
   prog.delete();
endtask

task automatic wait_halted(input int limit);
   int n;
   n = 0;
   while (!halted && n < limit) begin
      @(posedge clk);
      #1;
      n++;
   end
   if (!halted) begin
      $display("timeout: halted still low after %0d cycles", limit);
      errors++;
   end
endtask

`endif

/* tb/mc_tb.sv */
`default_nettype none

module mc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   logic             clk = 1'b0;
   logic             reset_n;
   logic             run;
   logic             prog_we;
   mc_pkg::core_id_t prog_core;
   mc_pkg::iadr_t    prog_adr;
   mc_pkg::word_t    prog_dat;
   mc_pkg::dadr_t    peek_adr;
   logic             halted;
   mc_pkg::count_t   cycles;
   mc_pkg::word_t    peek_dat;

   mc_pkg::word_t    prog [$];     // Program being built for one core.
   int               seed = 18;
   int               errors = 0;
   int               tests_ok = 0;
   int               tests_bad = 0;
   int               mark = 0;
   logic [7:0]       a;
   logic [7:0]       b;
   logic [7:0]       c;
   mc_pkg::count_t   snap;

   `include "mc_tb_programs.svh"

   mc_top i_dut (.*);

   always #4 clk = ~clk;

   task automatic check(input bit ok, input string msg);
      assert (ok) else begin
         $display("error at %0d ns: %s", $time, msg);
         errors++;
      end
   endtask

   task automatic check_peek(input mc_pkg::dadr_t adr, input mc_pkg::word_t exp);
      @(posedge clk);
      #1;
      peek_adr = adr;
      #1;
      check(peek_dat == exp,
            $sformatf("data[%0h] is %0h, expected %0h", adr, peek_dat, exp));
   endtask

   task automatic end_test(input string name);
      if (errors == mark) begin
         tests_ok++;
         $display("test %s: ok", name);
      end else begin
         tests_bad++;
         $display("test %s: failed", name);
      end
      mark = errors;
   endtask

   task automatic hold_reset();
      @(posedge clk);
      #1;
      run     = 1'b0;
      reset_n = 1'b0;
      repeat (8) @(posedge clk);
      #1;
   endtask

   task automatic start_run();
      reset_n = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b1;
   endtask

   initial begin
      reset_n   = 1'b0;
      run       = 1'b0;
      prog_we   = 1'b0;
      prog_core = '0;
      prog_adr  = '0;
      prog_dat  = '0;
      peek_adr  = '0;

      // Core 0 adds, core 1 stores, loads back and increments.
      a = 8'($random(seed));
      b = 8'($random(seed));
      c = 8'($random(seed));
      hold_reset();
      push_sum(a, b, 8'h10);
      load_program(1'b0);
      prog.push_back(enc_ldi(2'd2, c));
      prog.push_back(enc_st(2'd2, 8'h20));
      prog.push_back(enc_ld(2'd3, 8'h20));
      prog.push_back(enc_ldi(2'd1, 8'd1));
      prog.push_back(enc_add(2'd3, 2'd1));
      prog.push_back(enc_st(2'd3, 8'h21));
      prog.push_back(enc_halt());
      load_program(1'b1);
      start_run();
      wait_halted(2000);
      check_peek(8'h10, mc_pkg::word_t'(a) + mc_pkg::word_t'(b));
      end_test("arith_store");
      check_peek(8'h21, mc_pkg::word_t'(c) + 16'd1);
      end_test("load_store");

      // Eight increments per core, in two runs of four.
      hold_reset();
      push_counter(8'h40, 1'b1, 0);
      load_program(1'b0);
      push_counter(8'h40, 1'b0, 6);   // Locks only after core 0 cleared the counter.
      load_program(1'b1);
      start_run();
      wait_halted(2000);
      check_peek(8'h40, 16'd8);
      hold_reset();                    // Lock table clears, data memory keeps the count.
      push_counter(8'h40, 1'b0, 0);
      load_program(1'b0);
      push_counter(8'h40, 1'b0, 0);
      load_program(1'b1);
      start_run();
      wait_halted(2000);
      check_peek(8'h40, 16'd16);
      end_test("mutex");

      hold_reset();
      prog.push_back(enc_halt());
      load_program(1'b0);
      push_nops(24);
      prog.push_back(enc_halt());
      load_program(1'b1);
      start_run();
      repeat (20) @(posedge clk);
      #1;
      check(i_dut.halt == 2'b01 && !halted, "halted is wrong while core 1 still runs");
      wait_halted(2000);
      snap = cycles;
      check(snap != 0, "cycle count is zero after the run");
      repeat (10) @(posedge clk);
      #1;
      check(cycles == snap, $sformatf("cycles moved from %0d to %0d", snap, cycles));
      end_test("halt_rule");

      c = 8'($random(seed));
      hold_reset();
      push_sum(8'h5a, 8'h00, 8'h31);
      load_program(1'b0);
      push_nops(4);
      push_sum(c, 8'd1, 8'h30);
      load_program(1'b1);
      start_run();
      wait_halted(2000);
      check_peek(8'h30, mc_pkg::word_t'(c) + 16'd1);
      check_peek(8'h31, 16'h005a);
      hold_reset();
      prog.push_back(enc_ldi(2'd0, 8'd0));
      prog.push_back(enc_st(2'd0, 8'h30));   // Wipes core 1's result before it is redone.
      push_sum(8'h50, 8'h55, 8'h31);
      load_program(1'b0);
      start_run();
      wait_halted(2000);
      check_peek(8'h30, mc_pkg::word_t'(c) + 16'd1);
      check_peek(8'h31, 16'h00a5);
      end_test("private_programs");

      check(halted, "halted is low before the second reset");
      hold_reset();
      check(!halted && cycles == 0,
            $sformatf("after reset halted is %0b and cycles is %0d", halted, cycles));
      a = 8'($random(seed));
      b = 8'($random(seed));
      push_sum(a, b, 8'h10);
      load_program(1'b0);
      prog.push_back(enc_halt());
      load_program(1'b1);
      start_run();
      wait_halted(2000);
      check_peek(8'h10, mc_pkg::word_t'(a) + mc_pkg::word_t'(b));
      end_test("reset");

      $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
